/* common/rvv_defs.svh */
`ifndef RVV_DEFS_SVH
`define RVV_DEFS_SVH

// Command queue entries and the core's starting instruction credits
`define CMDQ_DEPTH 4

// ALU micro-op buffer entries and the decoder's starting credits
`define UOPQ_CREDITS 2

// Retire credits the ALU holds out of reset
`define RT_CREDITS 2

// Vector register file size
`define NUM_VREG 32

`endif

/* common/rvv_pkg.sv */
`default_nettype none

package rvv_pkg;

  typedef enum logic [2:0] {
    OP_SPLAT = 3'd0,
    OP_ADD   = 3'd1,
    OP_SUB   = 3'd2,
    OP_AND   = 3'd3,
    OP_SADDU = 3'd4
  } rvv_op_e;

  // Bit 31 selects the view: 0 is arithmetic, 1 is configuration
  typedef union packed {
    struct packed {
      logic       fmt;
      rvv_op_e    opcode;
      logic [4:0] vd;
      logic [4:0] vs2;
      logic [4:0] vs1;
      logic [4:0] simm5;
      logic [7:0] unused;
    } arith;
    // LMUL code 0 is 1, 1 is 2, 2 is 4
    struct packed {
      logic        fmt;
      logic [1:0]  lmul;
      logic [28:0] unused;
    } cfg;
  } rvv_inst_t;

  typedef struct packed {
    rvv_op_e    op;
    logic [4:0] vd;
    logic [4:0] vs1;
    logic [4:0] vs2;
    logic [4:0] simm5;
    logic       last;
  } rvv_uop_t;

endpackage

`default_nettype wire

/* common/uop_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface uop_if
  import rvv_pkg::*;
();

  logic     valid;
  rvv_uop_t uop;
  // One pulse per micro-op the ALU drains from its buffer
  logic     credit;

  modport issue (
    output valid,
    output uop,
    input  credit
  );

  modport exec (
    input  valid,
    input  uop,
    output credit
  );

endinterface

`default_nettype wire

/* source/rvv_cmd_queue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_defs.svh"

module rvv_cmd_queue
  import rvv_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      push_i,
  input  wire rvv_inst_t push_data_i,
  input  wire logic      pop_i,
  output rvv_inst_t      head_o,
  output logic           empty_o,
  output logic           credit_o
);

  localparam int AW = $clog2(`CMDQ_DEPTH);
  localparam int CW = $clog2(`CMDQ_DEPTH + 1);

  rvv_inst_t     mem_q [`CMDQ_DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    return (ptr == AW'(`CMDQ_DEPTH - 1)) ? '0 : ptr + AW'(1);
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q  <= count_q + CW'(push_i) - CW'(pop_i);
      // Core gets its credit back one cycle after the pop
      credit_o <= pop_i;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

/* decode/rvv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_defs.svh"

module rvv_decode
  import rvv_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire rvv_inst_t head_i,
  input  wire logic      empty_i,
  output logic           pop_o,
  uop_if.issue           uop
);

  localparam int CW = $clog2(`UOPQ_CREDITS + 1);

  logic [2:0]    lmul_q;
  logic [1:0]    step_q;
  logic [CW-1:0] credit_q;
  logic          valid_q;
  rvv_uop_t      uop_q;
  logic          is_cfg;
  logic          emit;
  logic          last_step;

  assign is_cfg    = head_i.cfg.fmt;
  assign last_step = ({1'b0, step_q} == lmul_q - 3'd1);
  assign emit      = !empty_i && !is_cfg && (credit_q != '0);

  // Arithmetic stays at the head until its whole group is issued
  assign pop_o = !empty_i && (is_cfg || (emit && last_step));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lmul_q   <= 3'd1;
      step_q   <= 2'd0;
      credit_q <= CW'(`UOPQ_CREDITS);
      valid_q  <= 1'b0;
    end else begin
      valid_q  <= emit;
      credit_q <= credit_q - CW'(emit) + CW'(uop.credit);
      if (emit) begin
        step_q <= last_step ? 2'd0 : step_q + 2'd1;
      end
      if (!empty_i && is_cfg) begin
        case (head_i.cfg.lmul)
          2'd0:    lmul_q <= 3'd1;
          2'd1:    lmul_q <= 3'd2;
          2'd2:    lmul_q <= 3'd4;
          // Reserved code leaves LMUL alone
          default: lmul_q <= lmul_q;
        endcase
      end
    end
  end

  // Register indices advance by the step within the group
  always_ff @(posedge clk) begin
    if (emit) begin
      uop_q.op    <= head_i.arith.opcode;
      uop_q.vd    <= head_i.arith.vd + {3'b000, step_q};
      uop_q.vs1   <= head_i.arith.vs1 + {3'b000, step_q};
      uop_q.vs2   <= head_i.arith.vs2 + {3'b000, step_q};
      uop_q.simm5 <= head_i.arith.simm5;
      uop_q.last  <= last_step;
    end
  end

  assign uop.valid = valid_q;
  assign uop.uop   = uop_q;

endmodule

`default_nettype wire

/* source/rvv_alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_defs.svh"

module rvv_alu
  import rvv_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  uop_if.exec              uop,
  output logic [4:0]       rd_idx_a_o,
  output logic [4:0]       rd_idx_b_o,
  input  wire logic [31:0] rd_data_a_i,
  input  wire logic [31:0] rd_data_b_i,
  input  wire logic        rt_credit_i,
  output logic             rt_valid_o,
  output logic [4:0]       rt_index_o,
  output logic [31:0]      rt_data_o,
  output logic             rt_vxsat_o,
  output logic             rt_last_o
);

  localparam int BW = $clog2(`UOPQ_CREDITS);
  localparam int CW = $clog2(`UOPQ_CREDITS + 1);
  localparam int RW = $clog2(`RT_CREDITS + 1);

  rvv_uop_t      buf_q [`UOPQ_CREDITS];
  logic [BW-1:0] wr_ptr_q;
  logic [BW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic [RW-1:0] rt_cnt_q;
  logic          credit_q;
  rvv_uop_t      head;
  logic          load;
  logic [31:0]   res_data;
  logic          res_sat;
  logic [7:0]    lane_a;
  logic [7:0]    lane_b;
  logic [8:0]    lane_sum;

  assign head       = buf_q[rd_ptr_q];
  assign load       = (count_q != '0) && (rt_cnt_q != '0);
  assign rd_idx_a_o = head.vs1;
  assign rd_idx_b_o = head.vs2;

  // Four independent byte lanes, vd = vs2 op vs1
  always_comb begin
    res_data = '0;
    res_sat  = 1'b0;
    lane_a   = '0;
    lane_b   = '0;
    lane_sum = '0;
    for (int i = 0; i < 4; i++) begin
      lane_a   = rd_data_a_i[8*i +: 8];
      lane_b   = rd_data_b_i[8*i +: 8];
      lane_sum = {1'b0, lane_b} + {1'b0, lane_a};
      case (head.op)
        OP_SPLAT: res_data[8*i +: 8] = {{3{head.simm5[4]}}, head.simm5};
        OP_ADD:   res_data[8*i +: 8] = lane_sum[7:0];
        OP_SUB:   res_data[8*i +: 8] = lane_b - lane_a;
        OP_AND:   res_data[8*i +: 8] = lane_b & lane_a;
        OP_SADDU: begin
          res_data[8*i +: 8] = lane_sum[8] ? 8'hff : lane_sum[7:0];
          res_sat            = res_sat | lane_sum[8];
        end
        default:  res_data[8*i +: 8] = 8'h00;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      credit_q   <= 1'b0;
      rt_cnt_q   <= RW'(`RT_CREDITS);
      rt_valid_o <= 1'b0;
      rt_index_o <= '0;
      rt_data_o  <= '0;
      rt_vxsat_o <= 1'b0;
      rt_last_o  <= 1'b0;
    end else begin
      if (uop.valid) begin
        wr_ptr_q <= (wr_ptr_q == BW'(`UOPQ_CREDITS - 1)) ? '0 : wr_ptr_q + BW'(1);
      end
      if (load) begin
        rd_ptr_q <= (rd_ptr_q == BW'(`UOPQ_CREDITS - 1)) ? '0 : rd_ptr_q + BW'(1);
      end
      count_q  <= count_q + CW'(uop.valid) - CW'(load);
      credit_q <= load;
      // A retire credit is spent when the beat is loaded
      rt_cnt_q   <= rt_cnt_q - RW'(load) + RW'(rt_credit_i);
      rt_valid_o <= load;
      if (load) begin
        rt_index_o <= head.vd;
        rt_data_o  <= res_data;
        rt_vxsat_o <= res_sat;
        rt_last_o  <= head.last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (uop.valid) begin
      buf_q[wr_ptr_q] <= uop.uop;
    end
  end

  assign uop.credit = credit_q;

endmodule

`default_nettype wire

/* source/rvv_vrf.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_defs.svh"

module rvv_vrf (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [4:0]  rd_idx_a_i,
  input  wire logic [4:0]  rd_idx_b_i,
  output logic [31:0]      rd_data_a_o,
  output logic [31:0]      rd_data_b_o,
  input  wire logic        wr_en_i,
  input  wire logic [4:0]  wr_idx_i,
  input  wire logic [31:0] wr_data_i
);

  logic [31:0] regs_q [`NUM_VREG];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_VREG; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Bypass lets a dependent micro-op see the value being written this cycle
  assign rd_data_a_o = (wr_en_i && (wr_idx_i == rd_idx_a_i)) ? wr_data_i
                                                              : regs_q[rd_idx_a_i];
  assign rd_data_b_o = (wr_en_i && (wr_idx_i == rd_idx_b_i)) ? wr_data_i
                                                              : regs_q[rd_idx_b_i];

endmodule

`default_nettype wire

/* source/rvv_backend.sv */
`timescale 1ns/10ps
`default_nettype none

module rvv_backend (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        inst_valid_i,
  input  wire logic [31:0] inst_i,
  output logic             inst_credit_o,
  output logic             rt_valid_o,
  output logic [4:0]       rt_index_o,
  output logic [31:0]      rt_data_o,
  output logic             rt_vxsat_o,
  output logic             rt_last_o,
  input  wire logic        rt_credit_i
);

  logic [31:0] cq_head;
  logic        cq_empty;
  logic        cq_pop;
  logic [4:0]  rd_idx_a;
  logic [4:0]  rd_idx_b;
  logic [31:0] rd_data_a;
  logic [31:0] rd_data_b;

  uop_if uop_bus ();

  rvv_cmd_queue cmd_queue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (inst_valid_i),
    .push_data_i (inst_i),
    .pop_i       (cq_pop),
    .head_o      (cq_head),
    .empty_o     (cq_empty),
    .credit_o    (inst_credit_o)
  );

  rvv_decode decode_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .head_i  (cq_head),
    .empty_i (cq_empty),
    .pop_o   (cq_pop),
    .uop     (uop_bus.issue)
  );

  rvv_alu alu_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .uop         (uop_bus.exec),
    .rd_idx_a_o  (rd_idx_a),
    .rd_idx_b_o  (rd_idx_b),
    .rd_data_a_i (rd_data_a),
    .rd_data_b_i (rd_data_b),
    .rt_credit_i (rt_credit_i),
    .rt_valid_o  (rt_valid_o),
    .rt_index_o  (rt_index_o),
    .rt_data_o   (rt_data_o),
    .rt_vxsat_o  (rt_vxsat_o),
    .rt_last_o   (rt_last_o)
  );

  // Retire beat doubles as the register write
  rvv_vrf vrf_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_idx_a_i  (rd_idx_a),
    .rd_idx_b_i  (rd_idx_b),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b),
    .wr_en_i     (rt_valid_o),
    .wr_idx_i    (rt_index_o),
    .wr_data_i   (rt_data_o)
  );

endmodule

`default_nettype wire

/* tests/rvv_backend_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_defs.svh"

module rvv_backend_assertions (
  input wire logic                                clk,
  input wire logic                                rst_n,
  input wire logic                                inst_valid_i,
  input wire logic                                inst_credit_i,
  input wire logic                                rt_valid_i,
  input wire logic                                rt_credit_i,
  input wire logic [$clog2(`RT_CREDITS + 1)-1:0] rt_cnt_i
);

  // Retire credits the ALU should still hold, as seen from the ports
  int   rt_avail_q;
  // Instructions pushed and not yet acknowledged
  int   pending_q;
  // Set by the first instruction after reset
  logic pushed_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rt_avail_q <= `RT_CREDITS;
      pending_q  <= 0;
      pushed_q   <= 1'b0;
    end else begin
      rt_avail_q <= rt_avail_q - int'(rt_valid_i) + int'(rt_credit_i);
      pending_q  <= pending_q + int'(inst_valid_i) - int'(inst_credit_i);
      if (inst_valid_i) begin
        pushed_q <= 1'b1;
      end
    end
  end

  // The ALU's own retire credit counter
  rt_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    rt_cnt_i <= `RT_CREDITS)
    else $error("retire credit count above its limit");

  rt_beat_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    rt_valid_i |-> rt_avail_q > 0)
    else $error("retire beat without a credit");

  rt_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    rt_valid_i |-> pushed_q)
    else $error("retire valid after reset before any instruction was pushed");

  inst_credit_after_push: assert property (@(posedge clk) disable iff (!rst_n)
    inst_credit_i |-> pending_q > 0)
    else $error("instruction credit without an outstanding push");

endmodule

bind rvv_backend rvv_backend_assertions assertions_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .inst_valid_i  (inst_valid_i),
  .inst_credit_i (inst_credit_o),
  .rt_valid_i    (rt_valid_o),
  .rt_credit_i   (rt_credit_i),
  .rt_cnt_i      (alu_i.rt_cnt_q)
);

`default_nettype wire

/* tests/rvv_backend_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_defs.svh"

module rvv_backend_tb;

  localparam int TIMEOUT = 400;

  logic        clk;
  logic        rst_n;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic        inst_credit_o;
  logic        rt_valid_o;
  logic [4:0]  rt_index_o;
  logic [31:0] rt_data_o;
  logic        rt_vxsat_o;
  logic        rt_last_o;
  logic        rt_credit_i;

  // Expected retire record is {index, data, vxsat, last}
  logic [38:0] exp_q [$];
  string       cur_test;
  int          errors;
  int          tests_run;
  int          inst_cred;
  int          sent;
  int          returned;
  int          owed;
  int          hold_left;
  int          hold_beats;
  logic        stall_seen;

  rvv_backend dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .inst_credit_o (inst_credit_o),
    .rt_valid_o    (rt_valid_o),
    .rt_index_o    (rt_index_o),
    .rt_data_o     (rt_data_o),
    .rt_vxsat_o    (rt_vxsat_o),
    .rt_last_o     (rt_last_o),
    .rt_credit_i   (rt_credit_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    end
  endtask

  // One cycle, inputs change just after the edge
  task automatic tick();
    @(posedge clk);
    #1;
    inst_valid_i = 1'b0;
    rt_credit_i  = 1'b0;
    if (hold_left > 0) begin
      hold_left--;
    end else if (owed > 0) begin
      owed--;
      rt_credit_i = 1'b1;
    end
  endtask

  task automatic send(logic [31:0] word);
    int waited;
    waited = 0;
    tick();
    while (inst_cred == 0 && waited < TIMEOUT) begin
      stall_seen = 1'b1;
      tick();
      waited++;
    end
    if (inst_cred == 0) begin
      errors++;
      $display("%s: no instruction credit came back in time", cur_test);
    end else begin
      inst_valid_i = 1'b1;
      inst_i       = word;
      inst_cred--;
      sent++;
    end
  endtask

  task automatic finish_test(int errs_before);
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || hold_left > 0 || owed > 0) && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: %0d expected retire beats never appeared", cur_test, exp_q.size());
      exp_q.delete();
    end
    tests_run++;
    $display("test %-8s %s", cur_test, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  always @(negedge clk) begin : watch_outputs
    logic [38:0] rec;
    if (rst_n) begin
      if (inst_credit_o) begin
        inst_cred++;
        returned++;
      end
      if (rt_valid_o) begin
        owed++;
        if (hold_left > 0) begin
          hold_beats++;
          if (hold_beats > `RT_CREDITS) begin
            errors++;
            $display("%s: retire beat %0d while credits were withheld", cur_test, hold_beats);
          end
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: unexpected retire beat to v%0d", cur_test, rt_index_o);
        end else begin
          rec = exp_q.pop_front();
          check("index", rec[38:34], rt_index_o);
          check("data", rec[33:2], rt_data_o);
          check("vxsat", rec[1], rt_vxsat_o);
          check("last", rec[0], rt_last_o);
        end
      end
    end
  end

  initial begin
    int          fd;
    int          code;
    int          n;
    int          waited;
    int          errs_before;
    logic        in_test;
    string       kind;
    string       line;
    logic [31:0] word;
    logic [31:0] idx;
    logic [31:0] data;
    logic [31:0] sat;
    logic [31:0] last;

    void'($urandom(32'hded0));
    rst_n        = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    rt_credit_i  = 1'b0;
    errors       = 0;
    tests_run    = 0;
    inst_cred    = `CMDQ_DEPTH;
    sent         = 0;
    returned     = 0;
    owed         = 0;
    hold_left    = 0;
    hold_beats   = 0;
    stall_seen   = 1'b0;
    in_test      = 1'b0;
    errs_before  = 0;
    cur_test     = "reset";
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fd = $fopen("tests/rvv_backend_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the test data file");
    end else begin
      while ($fscanf(fd, "%s", kind) == 1) begin
        case (kind)
          "#": code = $fgets(line, fd);
          "test": begin
            if (in_test) begin
              finish_test(errs_before);
            end
            code        = $fscanf(fd, "%s", cur_test);
            in_test     = 1'b1;
            errs_before = errors;
          end
          "inst": begin
            code = $fscanf(fd, "%h", word);
            send(word);
          end
          "exp": begin
            code = $fscanf(fd, "%h %h %h %h", idx, data, sat, last);
            exp_q.push_back({idx[4:0], data, sat[0], last[0]});
          end
          "hold": begin
            code       = $fscanf(fd, "%d", n);
            hold_left  = n + int'($urandom % 8);
            hold_beats = 0;
          end
          default: begin
            errors++;
            $display("unknown record %s in the test data file", kind);
          end
        endcase
      end
      if (in_test) begin
        finish_test(errs_before);
      end
      $fclose(fd);
    end

    // Every instruction must be acknowledged exactly once
    cur_test    = "credits";
    errs_before = errors;
    waited      = 0;
    while (inst_cred != `CMDQ_DEPTH && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    check("returned", sent, returned);
    check("held", `CMDQ_DEPTH, inst_cred);
    check("stalled", 1, stall_seen);
    finish_test(errs_before);

    $display("%0d tests, %0d instructions, %0d errors", tests_run, sent, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/rvv_pkg.sv
common/uop_if.sv
source/rvv_cmd_queue.sv
decode/rvv_decode.sv
source/rvv_alu.sv
source/rvv_vrf.sv
source/rvv_backend.sv
tests/rvv_backend_assertions.sv
tests/rvv_backend_tb.sv

/* tests/rvv_backend_testdata.txt */
# records: test <name> | inst <word> | exp <vd> <data> <vxsat> <last> | hold <cycles>
# words, vd, data, vxsat and last are hex, hold cycles are decimal
test splat
inst 00800500 exp 01 05050505 0 1
inst 01001d00 exp 02 fdfdfdfd 0 1
inst 01800f00 exp 03 0f0f0f0f 0 1
inst 02001000 exp 04 f0f0f0f0 0 1
test arith
inst 12882000 exp 05 02020202 0 1
inst 23046000 exp 06 f6f6f6f6 0 1
inst 33888000 exp 07 f0f0f0f0 0 1
test saddu
inst 44046000 exp 08 14141414 0 1
inst 44888000 exp 09 ffffffff 1 1
test lmul4
inst c0000000
inst 08000700 exp 10 07070707 0 0 exp 11 07070707 0 0
exp 12 07070707 0 0 exp 13 07070707 0 1
inst 1a420000 exp 14 0e0e0e0e 0 0 exp 15 0e0e0e0e 0 0
exp 16 0e0e0e0e 0 0 exp 17 0e0e0e0e 0 1
inst 80000000
test hold
hold 40
inst 0c000100 exp 18 01010101 0 1
inst 0c800200 exp 19 02020202 0 1
inst 0d000300 exp 1a 03030303 0 1
inst 0d800400 exp 1b 04040404 0 1
inst 0e000500 exp 1c 05050505 0 1
inst 0e800600 exp 1d 06060606 0 1
inst 0f001f00 exp 1e ffffffff 0 1
inst 0f801800 exp 1f f8f8f8f8 0 1
inst 15632000 exp 0a 03030303 0 1
